//--- run_sim.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it.
# The result is read from the simulation log.

set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_subsystem -f sim.f -o sim_bin

./obj_dir/sim_bin > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

//--- sim.f
+incdir+tb
src/soc_bus_pkg.sv
src/soc_map_pkg.sv
src/addr_decoder.sv
src/req_fifo.sv
src/target_bank.sv
src/mem_subsystem_top.sv
tb/tb_mem_subsystem.sv

//--- src/addr_decoder.sv
// Address decoder at the front of the subsystem.
// Matches each incoming request against the ROM and scratchpad rules and
// tags it with the region it hits, or REGION_NONE. Purely combinational,
// so the handshake passes straight through.

`timescale 1ns/1ps

module addr_decoder (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  // upstream request
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  soc_bus_pkg::bus_req_t    req_i,
  // tagged request towards the buffer
  output logic                     dec_valid_o,
  input  logic                     dec_ready_i,
  output soc_map_pkg::routed_req_t dec_req_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  addr_t rom_off;
  addr_t spm_off;
  logic  rom_hit;
  logic  spm_hit;

  // ----------------------------------------------------------------------
  // rule match
  // ----------------------------------------------------------------------
  // a rule covers [base, base + length); the unsigned offset wraps
  // for addresses below base and so fails the compare too
  assign rom_off = req_i.addr - RomBase;
  assign spm_off = req_i.addr - SpmBase;
  assign rom_hit = (rom_off < RomLength);
  assign spm_hit = (spm_off < SpmLength);

  always_comb begin
    dec_req_o.req = req_i;
    if (rom_hit) begin
      dec_req_o.region = REGION_ROM;
    end else if (spm_hit) begin
      dec_req_o.region = REGION_SPM;
    end else begin
      // no default port, the target bank answers with an error
      dec_req_o.region = REGION_NONE;
    end
  end

  assign dec_valid_o = req_valid_i;
  assign req_ready_o = dec_ready_i;

  // regions must not overlap, otherwise the priority above hides one
  a_single_rule: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    req_valid_i |-> !(rom_hit && spm_hit)
  ) else $error("address %h matches more than one rule", req_i.addr);

endmodule

//--- src/mem_subsystem_top.sv
// Top level of the memory subsystem.
// Chains the address decoder, the request buffer and the target bank.
// Requests enter on the req_* ports and responses leave in request order
// on the resp_* ports, at least two cycles after the request transfer.

`timescale 1ns/1ps

module mem_subsystem_top #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  // request channel
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  soc_bus_pkg::bus_req_t  req_i,
  // response channel
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i,
  output soc_bus_pkg::bus_resp_t resp_o
);

  import soc_map_pkg::*;

  // decoder to buffer
  logic        dec_valid;
  logic        dec_ready;
  routed_req_t dec_req;

  // buffer to target bank
  logic        buf_valid;
  logic        buf_ready;
  routed_req_t buf_req;

  addr_decoder u_addr_decoder (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_i       ( req_i       ),
    .dec_valid_o ( dec_valid   ),
    .dec_ready_i ( dec_ready   ),
    .dec_req_o   ( dec_req     )
  );

  req_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_req_fifo (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .in_valid_i  ( dec_valid  ),
    .in_ready_o  ( dec_ready  ),
    .in_req_i    ( dec_req    ),
    .out_valid_o ( buf_valid  ),
    .out_ready_i ( buf_ready  ),
    .out_req_o   ( buf_req    )
  );

  target_bank u_target_bank (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .in_valid_i   ( buf_valid    ),
    .in_ready_o   ( buf_ready    ),
    .in_req_i     ( buf_req      ),
    .resp_valid_o ( resp_valid_o ),
    .resp_ready_i ( resp_ready_i ),
    .resp_o       ( resp_o       )
  );

endmodule

//--- src/req_fifo.sv
// Register cut between the decoder and the target bank.
// A circular buffer of FIFO_DEPTH tagged requests with read and write
// pointers and a fill count. An entry shows up on the output the cycle
// after it was accepted; the input is not ready while the buffer is full.

`timescale 1ns/1ps

module req_fifo #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  // from the decoder
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  soc_map_pkg::routed_req_t in_req_i,
  // to the target bank
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output soc_map_pkg::routed_req_t out_req_o
);

  import soc_map_pkg::*;

  localparam int unsigned PtrWidth = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CntWidth = $clog2(FIFO_DEPTH + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  localparam ptr_t LastPtr = ptr_t'(FIFO_DEPTH - 1);
  localparam cnt_t FullCnt = cnt_t'(FIFO_DEPTH);

  routed_req_t mem_q [FIFO_DEPTH];
  ptr_t        wr_ptr_q;
  ptr_t        rd_ptr_q;
  cnt_t        count_q;
  logic        push;
  logic        pop;

  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == LastPtr) ? ptr_t'(0) : ptr_t'(ptr + 1'b1);
  endfunction

  assign in_ready_o  = (count_q != FullCnt);
  assign out_valid_o = (count_q != '0);
  assign out_req_o   = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  // ----------------------------------------------------------------------
  // storage and pointers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // push and pop together leave the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  a_count_bound: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    count_q <= FullCnt
  ) else $error("fill count above depth");

  // a stalled head entry must not be overwritten by a later push
  a_out_stable: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_req_o)
  ) else $error("buffer output changed while stalled");

endmodule

//--- src/soc_bus_pkg.sv
// Bus-level definitions shared by every stage of the memory subsystem.
// Holds the address and data widths, their vector types and the packed
// request and response structs that travel over the valid/ready channels.
// Import it wherever a bus request or response is built or taken apart.

package soc_bus_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  // one enable bit per data byte
  localparam int unsigned StrbWidth = DataWidth / 8;

  // ----------------------------------------------------------------------
  // vector types
  // ----------------------------------------------------------------------
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // ----------------------------------------------------------------------
  // channel payloads
  // ----------------------------------------------------------------------

  // request channel, 69 bits
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    // byte enables, only meaningful on writes
    strb_t be;
  } bus_req_t;

  // response channel, 33 bits
  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_resp_t;

endpackage

//--- src/soc_map_pkg.sv
// Address map of the subsystem: the target regions, their base and
// length, the boot ROM content rule and the request type that carries
// its decoded region from the decoder down to the targets.
// Builds on the bus package for the address and data types.

package soc_map_pkg;

  import soc_bus_pkg::*;

  // ----------------------------------------------------------------------
  // regions
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_SPM,
    REGION_NONE
  } region_e;

  // boot ROM, read only
  localparam addr_t RomBase   = 32'h0000_1000;
  localparam addr_t RomLength = 32'h0000_1000;

  // scratchpad, read/write with byte enables
  localparam addr_t SpmBase   = 32'h1000_0000;
  localparam addr_t SpmLength = 32'h0000_0400;

  localparam int unsigned SpmWords = 256;

  typedef logic [$clog2(SpmWords)-1:0] spm_index_t;

  // ----------------------------------------------------------------------
  // ROM content
  // ----------------------------------------------------------------------
  localparam data_t RomPattern = 32'hB007_0000;

  // each ROM word is its own address xor'ed with the pattern
  function automatic data_t rom_word(addr_t addr);
    return data_t'(addr) ^ RomPattern;
  endfunction

  // ----------------------------------------------------------------------
  // decoded request, 71 bits
  // ----------------------------------------------------------------------
  typedef struct packed {
    bus_req_t req;
    region_e  region;
  } routed_req_t;

endpackage

//--- src/target_bank.sv
// Target side of the subsystem: the boot ROM and the scratchpad.
// Takes one tagged request at a time and answers through a single
// response register, one cycle after acceptance. ROM writes and requests
// that hit no region get an error response with zero read data.

`timescale 1ns/1ps

module target_bank (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  // from the buffer
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  soc_map_pkg::routed_req_t in_req_i,
  // external response channel
  output logic                     resp_valid_o,
  input  logic                     resp_ready_i,
  output soc_bus_pkg::bus_resp_t   resp_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  data_t      spm_q [SpmWords];
  addr_t      spm_off;
  spm_index_t spm_idx;
  logic       accept;
  logic       spm_we;
  bus_resp_t  resp_d;
  bus_resp_t  resp_q;
  logic       resp_valid_q;

  // register is free, or drains in this same cycle
  assign in_ready_o = !resp_valid_q || resp_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  // word offset inside the scratchpad
  assign spm_off = in_req_i.req.addr - SpmBase;
  assign spm_idx = spm_index_t'(spm_off >> 2);

  // ----------------------------------------------------------------------
  // response decision
  // ----------------------------------------------------------------------
  always_comb begin
    resp_d = '0;
    spm_we = 1'b0;
    case (in_req_i.region)
      REGION_ROM: begin
        if (in_req_i.req.we) begin
          // read only, the write is dropped
          resp_d.err = 1'b1;
        end else begin
          resp_d.rdata = rom_word(in_req_i.req.addr);
        end
      end
      REGION_SPM: begin
        if (in_req_i.req.we) begin
          spm_we = accept;
        end else begin
          resp_d.rdata = spm_q[spm_idx];
        end
      end
      default: begin
        resp_d.err = 1'b1;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // scratchpad
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      for (int w = 0; w < SpmWords; w++) begin
        spm_q[w] <= '0;
      end
    end else if (spm_we) begin
      // merge only the enabled bytes
      for (int b = 0; b < StrbWidth; b++) begin
        if (in_req_i.req.be[b]) begin
          spm_q[spm_idx][8*b +: 8] <= in_req_i.req.wdata[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // response register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q <= resp_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

  a_resp_stable: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o)
  ) else $error("response changed while stalled");

endmodule

//--- tb/tb_ref_model.svh
// Reference model for the memory subsystem testbench.
// Decodes addresses against the address map, predicts each response and
// keeps its own copy of the scratchpad. Also holds the typed compare tasks.
// Included inside the body of the testbench module.

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

data_t spm_model [SpmWords];

function automatic void clear_spm_model();
  for (int i = 0; i < SpmWords; i++) begin
    spm_model[i] = '0;
  end
endfunction

// region bounds, end address excluded
function automatic region_e decode_region(addr_t addr);
  if (addr >= RomBase && addr < RomBase + RomLength) begin
    return REGION_ROM;
  end
  if (addr >= SpmBase && addr < SpmBase + SpmLength) begin
    return REGION_SPM;
  end
  return REGION_NONE;
endfunction

// predicts the response and applies writes to the scratchpad copy
function automatic bus_resp_t expected_response(bus_req_t req);
  bus_resp_t   resp;
  data_t       mask;
  int unsigned idx;
  resp = '0;
  mask = {{8{req.be[3]}}, {8{req.be[2]}}, {8{req.be[1]}}, {8{req.be[0]}}};
  case (decode_region(req.addr))
    REGION_ROM: begin
      if (req.we) begin
        resp.err = 1'b1;
      end else begin
        resp.rdata = req.addr ^ RomPattern;
      end
    end
    REGION_SPM: begin
      idx = (req.addr - SpmBase) / 4;
      if (req.we) begin
        spm_model[idx] = (spm_model[idx] & ~mask) | (req.wdata & mask);
      end else begin
        resp.rdata = spm_model[idx];
      end
    end
    default: begin
      resp.err = 1'b1;
    end
  endcase
  return resp;
endfunction

function automatic string describe_access(bus_req_t req);
  case (decode_region(req.addr))
    REGION_ROM: return req.we ? "rom write" : "rom read";
    REGION_SPM: return req.we ? "spm write" : "spm read";
    default:    return req.we ? "unmapped write" : "unmapped read";
  endcase
endfunction

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------
task automatic check_resp(string name, soc_bus_pkg::bus_resp_t exp,
                          soc_bus_pkg::bus_resp_t act);
  if (act !== exp) begin
    $display("FAIL %s: expected rdata=%h err=%b, actual rdata=%h err=%b",
             name, exp.rdata, exp.err, act.rdata, act.err);
    stop_with_failure();
  end
endtask

task automatic check_region(string name, soc_map_pkg::region_e exp,
                            soc_map_pkg::region_e act);
  if (act !== exp) begin
    $display("FAIL %s: expected %s, actual %s", name, exp.name(), act.name());
    stop_with_failure();
  end
endtask

task automatic check_flag(string name, logic exp, logic act);
  if (act !== exp) begin
    $display("FAIL %s: expected %b, actual %b", name, exp, act);
    stop_with_failure();
  end
endtask

// model decode at the region edges
task automatic self_check_decode();
  check_region("decode rom first", REGION_ROM, decode_region(RomBase));
  check_region("decode rom last", REGION_ROM, decode_region(RomBase + RomLength - 4));
  check_region("decode above rom", REGION_NONE, decode_region(RomBase + RomLength));
  check_region("decode below rom", REGION_NONE, decode_region(RomBase - 1));
  check_region("decode spm first", REGION_SPM, decode_region(SpmBase));
  check_region("decode spm last", REGION_SPM, decode_region(SpmBase + SpmLength - 1));
  check_region("decode above spm", REGION_NONE, decode_region(SpmBase + SpmLength));
  check_region("decode zero", REGION_NONE, decode_region(32'h0));
endtask

`endif

//--- tb/tb_mem_subsystem.sv
// Testbench for the memory subsystem top level.
// Drives random requests into the boot ROM, the scratchpad and unmapped
// space, holds the response channel back at random, and checks every
// response in request order against the reference model.

`timescale 1ns/1ps

module tb_mem_subsystem;

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int ClkHalfPeriod  = 10;
  localparam int ResetCycles    = 16;
  localparam int SeedValue      = 48;
  localparam int NumTxn         = 600;
  // chance in percent of offering a new request in a cycle
  localparam int ValidPct       = 70;
  // chance in percent of holding resp_ready_i low in a cycle
  localparam int ReadyLowPct    = 30;
  localparam int WatchdogCycles = NumTxn * 40 + ResetCycles;

  logic      clk_i;
  logic      ndmreset_n;
  logic      req_valid_i;
  logic      req_ready_o;
  bus_req_t  req_i;
  logic      resp_valid_o;
  logic      resp_ready_i;
  bus_resp_t resp_o;

  integer    seed;
  int        issued;
  int        checked;
  logic      req_fire;
  logic      resp_fire;
  addr_t     last_spm_addr;
  bus_resp_t exp_q [$];
  string     name_q [$];

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  `include "tb_ref_model.svh"

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------
  // mostly ROM and scratchpad, the rest near the region edges or anywhere
  function automatic bus_req_t random_request();
    bus_req_t    req;
    int unsigned pick;
    pick      = {$random(seed)} % 100;
    req.we    = $random(seed);
    req.wdata = $random(seed);
    req.be    = $random(seed);
    if (pick < 35) begin
      req.addr = RomBase + addr_t'(({$random(seed)} % (RomLength / 4)) << 2);
    end else if (pick < 80) begin
      // reuse the last word half of the time, so reads follow writes
      if ({$random(seed)} % 2 == 0) begin
        req.addr = SpmBase + addr_t'(({$random(seed)} % SpmWords) << 2);
      end else begin
        req.addr = last_spm_addr;
      end
      last_spm_addr = req.addr;
    end else begin
      case ({$random(seed)} % 5)
        0:       req.addr = RomBase - 4;
        1:       req.addr = RomBase + RomLength;
        2:       req.addr = SpmBase - 4;
        3:       req.addr = SpmBase + SpmLength;
        default: req.addr = {$random(seed)};
      endcase
    end
    return req;
  endfunction

  mem_subsystem_top #(
    .FIFO_DEPTH ( 2 )
  ) UUT (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_o  ( req_ready_o  ),
    .req_i        ( req_i        ),
    .resp_valid_o ( resp_valid_o ),
    .resp_ready_i ( resp_ready_i ),
    .resp_o       ( resp_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #ClkHalfPeriod clk_i = ~clk_i;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("watchdog expired after %0d cycles with %0d of %0d responses checked",
             WatchdogCycles, checked, NumTxn);
    stop_with_failure();
  end

  initial begin
    seed          = SeedValue;
    req_valid_i   = 1'b0;
    req_i         = '0;
    resp_ready_i  = 1'b0;
    ndmreset_n    = 1'b0;
    issued        = 0;
    checked       = 0;
    last_spm_addr = SpmBase;
    clear_spm_model();
    self_check_decode();

    repeat (ResetCycles) begin
      @(negedge clk_i);
      check_flag("reset resp_valid", 1'b0, resp_valid_o);
    end
    @(posedge clk_i);
    ndmreset_n <= 1'b1;
    @(negedge clk_i);
    check_flag("after reset resp_valid", 1'b0, resp_valid_o);
    check_flag("after reset req_ready", 1'b1, req_ready_o);

    // ------------------------------------------------------------------
    // main loop, sample mid-cycle and drive on the rising edge
    // ------------------------------------------------------------------
    while (checked < NumTxn) begin
      @(negedge clk_i);
      req_fire  = req_valid_i && req_ready_o;
      resp_fire = resp_valid_o && resp_ready_i;
      if (resp_fire) begin
        if (exp_q.size() == 0) begin
          $display("a response arrived with no request outstanding");
          stop_with_failure();
        end else begin
          check_resp(name_q.pop_front(), exp_q.pop_front(), resp_o);
          checked++;
        end
      end
      if (req_fire) begin
        name_q.push_back($sformatf("txn %0d %s", issued, describe_access(req_i)));
        exp_q.push_back(expected_response(req_i));
        issued++;
      end
      @(posedge clk_i);
      if (req_fire || !req_valid_i) begin
        if (issued < NumTxn && ({$random(seed)} % 100) < ValidPct) begin
          req_valid_i <= 1'b1;
          req_i       <= random_request();
        end else begin
          req_valid_i <= 1'b0;
        end
      end
      resp_ready_i <= (({$random(seed)} % 100) >= ReadyLowPct);
    end

    // every response came once, nothing more may follow
    @(posedge clk_i);
    req_valid_i  <= 1'b0;
    resp_ready_i <= 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      check_flag("no extra response", 1'b0, resp_valid_o);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
